// ==== design/sched_pkg.sv ====
package sched_pkg;

  // job payload handed through to the worker
  localparam int JOB_DATA_W = 16;

  // absolute deadlines share the timebase width
  localparam int TAG_W = 16;

  // relative deadline that arrives with each job
  localparam int REL_DEADLINE_W = 8;

  // jobs refused while full, saturating
  localparam int DROP_COUNT_W = 8;

  typedef logic [JOB_DATA_W-1:0] job_data_t;

  typedef logic [TAG_W-1:0] tag_t;

  typedef logic [REL_DEADLINE_W-1:0] rel_deadline_t;

  typedef logic [DROP_COUNT_W-1:0] drop_count_t;

endpackage

// ==== design/queue_pkg.sv ====
package queue_pkg;

  // number of job slots
  localparam int QUEUE_DEPTH = 8;

  localparam int SLOT_W = $clog2(QUEUE_DEPTH);

  // slot index into the queue storage
  typedef logic [SLOT_W-1:0] slot_t;

  // occupancy needs one extra bit to reach QUEUE_DEPTH
  typedef logic [SLOT_W:0] count_t;

endpackage

// ==== design/job_stamper.sv ====
module job_stamper
  import sched_pkg::*;
(
  input  logic          clk_in,
  input  logic          rst_in,

  input  logic          job_valid,
  input  job_data_t     job_data,
  input  rel_deadline_t rel_deadline,

  input  logic          queue_full,
  output logic          job_ready,

  output logic          enq,
  output job_data_t     enq_data,
  output tag_t          enq_tag,

  output tag_t          now,
  output drop_count_t   dropped_count
);

  logic accept;
  logic drop;

  // full check is made here only, the queue takes every enq
  assign accept = job_valid && !queue_full;
  assign drop = job_valid && queue_full;

  assign job_ready = !queue_full;

  // timebase, enq strobe and drop counter
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      now <= '0;
      enq <= 1'b0;
      dropped_count <= '0;
    end else begin
      now <= now + tag_t'(1);
      enq <= accept;
      if (drop && (dropped_count != '1)) begin
        dropped_count <= dropped_count + drop_count_t'(1);
      end
    end
  end

  // absolute deadline is the timebase at the sampling edge plus the offset
  always_ff @(posedge clk_in) begin
    if (accept) begin
      enq_data <= job_data;
      enq_tag <= now + tag_t'(rel_deadline);
    end
  end

endmodule

// ==== design/free_slot_list.sv ====
module free_slot_list
  import queue_pkg::*;
(
  input  logic  clk_in,
  input  logic  rst_in,

  input  logic  take,

  input  logic  give,
  input  slot_t give_slot,

  output slot_t head_slot
);

  slot_t slot_list [QUEUE_DEPTH];
  slot_t rd_ptr;
  slot_t wr_ptr;

  // next free slot, valid whenever the queue is not full
  assign head_slot = slot_list[rd_ptr];

  // read pointer advances on every enqueue
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rd_ptr <= '0;
    end else if (take) begin
      rd_ptr <= rd_ptr + slot_t'(1);
    end
  end

  // write pointer starts on top of the read pointer since the list begins full
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
    end else if (give) begin
      wr_ptr <= wr_ptr + slot_t'(1);
    end
  end

  // every index present at reset
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        slot_list[i] <= slot_t'(i);
      end
    end else if (give) begin
      slot_list[wr_ptr] <= give_slot;
    end
  end

endmodule

// ==== design/tag_priority_queue.sv ====
module tag_priority_queue
  import sched_pkg::*;
  import queue_pkg::*;
(
  input  logic      clk_in,
  input  logic      rst_in,

  input  logic      enq,
  input  job_data_t enq_data,
  input  tag_t      enq_tag,

  input  logic      deq,

  output logic      queue_full,
  output logic      queue_empty,

  output logic      valid_out,
  output job_data_t data_out,
  output tag_t      tag_out
);

  tag_t      tag_mem  [QUEUE_DEPTH];
  job_data_t data_mem [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0] slot_valid;

  count_t count;
  slot_t  free_slot;
  logic   do_deq;

  slot_t min_slot;
  tag_t  min_tag;
  logic  min_found;

  // an enq in flight already claims its slot
  assign queue_full = (count == count_t'(QUEUE_DEPTH)) ||
                      (enq && (count == count_t'(QUEUE_DEPTH - 1)));
  assign queue_empty = (count == '0);

  assign do_deq = deq && !queue_empty;

  free_slot_list free_slot_list_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .take      (enq),
    .give      (do_deq),
    .give_slot (min_slot),
    .head_slot (free_slot)
  );

  // smallest valid tag, strict compare keeps ties on the lowest index
  always_comb begin
    min_slot = '0;
    min_tag = '1;
    min_found = 1'b0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      if (slot_valid[i] && (!min_found || (tag_mem[i] < min_tag))) begin
        min_slot = slot_t'(i);
        min_tag = tag_mem[i];
        min_found = 1'b1;
      end
    end
  end

  // control state
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      slot_valid <= '0;
      count <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= do_deq;

      // head slot is never valid, so no clash with min_slot
      if (do_deq) begin
        slot_valid[min_slot] <= 1'b0;
      end
      if (enq) begin
        slot_valid[free_slot] <= 1'b1;
      end

      case ({enq, do_deq})
        2'b10:   count <= count + count_t'(1);
        2'b01:   count <= count - count_t'(1);
        default: count <= count;
      endcase
    end
  end

  // slot storage
  always_ff @(posedge clk_in) begin
    if (enq) begin
      tag_mem[free_slot] <= enq_tag;
      data_mem[free_slot] <= enq_data;
    end
  end

  // popped job, qualified by valid_out
  always_ff @(posedge clk_in) begin
    if (do_deq) begin
      data_out <= data_mem[min_slot];
      tag_out <= min_tag;
    end
  end

endmodule

// ==== design/job_dispatcher.sv ====
module job_dispatcher
  import sched_pkg::*;
(
  input  logic      clk_in,
  input  logic      rst_in,

  input  logic      worker_ready,
  input  logic      queue_empty,
  input  tag_t      now,

  output logic      deq,

  input  logic      valid_out,
  input  job_data_t data_out,
  input  tag_t      tag_out,

  output logic      dispatch_valid,
  output job_data_t dispatch_data,
  output tag_t      dispatch_tag,
  output logic      dispatch_late
);

  // a deq is outstanding until the queue answers
  logic waiting;

  assign deq = worker_ready && !queue_empty && !waiting;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      waiting <= 1'b0;
      dispatch_valid <= 1'b0;
    end else begin
      if (valid_out) begin
        waiting <= 1'b0;
      end else if (deq) begin
        waiting <= 1'b1;
      end
      dispatch_valid <= valid_out;
    end
  end

  // late when the deadline already passed as the job leaves the queue
  always_ff @(posedge clk_in) begin
    if (valid_out) begin
      dispatch_data <= data_out;
      dispatch_tag <= tag_out;
      dispatch_late <= (tag_out < now);
    end
  end

endmodule

// ==== design/edf_scheduler_top.sv ====
module edf_scheduler_top
  import sched_pkg::*;
(
  input  logic          clk_in,
  input  logic          rst_in,

  input  logic          job_valid,
  input  job_data_t     job_data,
  input  rel_deadline_t rel_deadline,
  output logic          job_ready,

  input  logic          worker_ready,

  output logic          dispatch_valid,
  output job_data_t     dispatch_data,
  output tag_t          dispatch_tag,
  output logic          dispatch_late,

  output drop_count_t   dropped_count
);

  logic      queue_full;
  logic      queue_empty;
  logic      enq;
  job_data_t enq_data;
  tag_t      enq_tag;
  tag_t      now;
  logic      deq;
  logic      valid_out;
  job_data_t data_out;
  tag_t      tag_out;

  job_stamper job_stamper_i (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .job_valid     (job_valid),
    .job_data      (job_data),
    .rel_deadline  (rel_deadline),
    .queue_full    (queue_full),
    .job_ready     (job_ready),
    .enq           (enq),
    .enq_data      (enq_data),
    .enq_tag       (enq_tag),
    .now           (now),
    .dropped_count (dropped_count)
  );

  tag_priority_queue tag_priority_queue_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .enq         (enq),
    .enq_data    (enq_data),
    .enq_tag     (enq_tag),
    .deq         (deq),
    .queue_full  (queue_full),
    .queue_empty (queue_empty),
    .valid_out   (valid_out),
    .data_out    (data_out),
    .tag_out     (tag_out)
  );

  job_dispatcher job_dispatcher_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .worker_ready   (worker_ready),
    .queue_empty    (queue_empty),
    .now            (now),
    .deq            (deq),
    .valid_out      (valid_out),
    .data_out       (data_out),
    .tag_out        (tag_out),
    .dispatch_valid (dispatch_valid),
    .dispatch_data  (dispatch_data),
    .dispatch_tag   (dispatch_tag),
    .dispatch_late  (dispatch_late)
  );

endmodule

// ==== test/edf_scheduler_tb.sv ====
module edf_scheduler_tb
  import sched_pkg::*;
  import queue_pkg::*;
();

  localparam string STIM_FILE = "test/edf_stimulus.txt";

  logic          clk_in;
  logic          rst_in;
  logic          job_valid;
  job_data_t     job_data;
  rel_deadline_t rel_deadline;
  logic          job_ready;
  logic          worker_ready;
  logic          dispatch_valid;
  job_data_t     dispatch_data;
  tag_t          dispatch_tag;
  logic          dispatch_late;
  drop_count_t   dropped_count;

  // stimulus lines
  logic [7:0] ln_phase [$];
  int ln_cycles [$];
  int ln_jv [$];
  int ln_data [$];
  int ln_rel [$];
  int ln_wr [$];
  int ln_held [$];

  // reference model
  tag_t        exp_tag [$];
  job_data_t   exp_data [$];
  int          cyc;
  int          m_count;
  int          m_pend;
  int          lat_start;
  logic        m_wait;
  logic        m_vout;
  logic        m_dv;
  drop_count_t m_drop;
  tag_t        late_now;
  logic [7:0]  phase;

  int          fd;
  int          n;
  int          total_cycles;
  int          limit_cycles;
  int          tick;
  int          f_cyc;
  int          f_jv;
  int          f_jd;
  int          f_rel;
  int          f_wr;
  int          f_held;
  logic [7:0]  f_ph;
  logic [1023:0] line_buf;
  integer      seed;
  logic [31:0] rnd;

  edf_scheduler_top edf_scheduler_top_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .job_valid      (job_valid),
    .job_data       (job_data),
    .rel_deadline   (rel_deadline),
    .job_ready      (job_ready),
    .worker_ready   (worker_ready),
    .dispatch_valid (dispatch_valid),
    .dispatch_data  (dispatch_data),
    .dispatch_tag   (dispatch_tag),
    .dispatch_late  (dispatch_late),
    .dropped_count  (dropped_count)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_tag(input tag_t got, input tag_t exp);
    if (got !== exp) report_error($sformatf("dispatch_tag got %0d expected %0d", got, exp));
  endtask

  task automatic check_data(input job_data_t got, input job_data_t exp);
    if (got !== exp) report_error($sformatf("dispatch_data got %h expected %h", got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) report_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_count(input drop_count_t got, input drop_count_t exp);
    if (got !== exp) report_error($sformatf("dropped_count got %0d expected %0d", got, exp));
  endtask

  // one clock edge of the scheduler as seen from its ports
  task automatic model_edge();
    logic full;
    logic empty;
    logic deq_m;
    logic accept;
    full = (m_count + m_pend) >= QUEUE_DEPTH;
    empty = (m_count == 0);
    deq_m = worker_ready && !empty && !m_wait;
    accept = job_valid && !full;
    if (job_valid && full && (m_drop != '1)) begin
      m_drop = m_drop + 8'd1;
    end
    if (accept) begin
      exp_tag.push_back(tag_t'(cyc) + tag_t'(rel_deadline));
      exp_data.push_back(job_data);
      if (phase == "L") lat_start = cyc;
    end
    // now as the dispatcher sees it while the popped job is presented
    if (m_vout) late_now = tag_t'(cyc);
    m_dv = m_vout;
    if (m_vout) begin
      m_wait = 1'b0;
    end else if (deq_m) begin
      m_wait = 1'b1;
    end
    m_vout = deq_m;
    m_count = m_count + m_pend - (deq_m ? 1 : 0);
    m_pend = accept ? 1 : 0;
    cyc = cyc + 1;
  endtask

  task automatic check_dispatch();
    int idx;
    logic exp_late;
    idx = -1;
    if (exp_tag.size() == 0) report_error("dispatch while the model holds no job");
    if (phase == "R" || phase == "D") begin
      // unordered traffic so only locate the job
      foreach (exp_tag[j]) begin
        if (idx < 0 && exp_tag[j] == dispatch_tag && exp_data[j] == dispatch_data) idx = j;
      end
      if (idx < 0) begin
        report_error($sformatf("job %h tag %0d was never accepted", dispatch_data, dispatch_tag));
      end
    end else begin
      idx = 0;
      foreach (exp_tag[j]) begin
        if (exp_tag[j] < exp_tag[idx]) idx = j;
      end
    end
    exp_late = exp_tag[idx] < late_now;
    check_tag(dispatch_tag, exp_tag[idx]);
    check_data(dispatch_data, exp_data[idx]);
    check_flag(dispatch_late, exp_late, "dispatch_late");
    if (phase == "L" && (cyc - lat_start) != 4) begin
      report_error($sformatf("job latency %0d cycles, expected 4", cyc - lat_start));
    end
    exp_tag.delete(idx);
    exp_data.delete(idx);
  endtask

  task automatic check_outputs();
    check_flag(dispatch_valid, m_dv, "dispatch_valid");
    check_flag(job_ready, (m_count + m_pend) < QUEUE_DEPTH, "job_ready");
    check_count(dropped_count, m_drop);
    if (dispatch_valid) check_dispatch();
  endtask

  always @(posedge clk_in) begin
    tick <= tick + 1;
    if (limit_cycles > 0 && tick > limit_cycles) begin
      $display("timeout: the run hung and did not finish within %0d cycles", limit_cycles);
      abort_run();
    end
  end

  initial begin
    rst_in = 1'b1;
    job_valid = 1'b0;
    job_data = '0;
    rel_deadline = '0;
    worker_ready = 1'b0;
    tick = 0;
    limit_cycles = 0;
    total_cycles = 0;
    seed = 17;
    cyc = 0;
    m_count = 0;
    m_pend = 0;
    lat_start = 0;
    m_wait = 1'b0;
    m_vout = 1'b0;
    m_dv = 1'b0;
    m_drop = '0;
    late_now = '0;
    phase = " ";

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
      abort_run();
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", f_ph);
      if (n != 1) break;
      if (f_ph == "#") begin
        n = $fgets(line_buf, fd);
      end else begin
        n = $fscanf(fd, " %h %h %h %h %h %h", f_cyc, f_jv, f_jd, f_rel, f_wr, f_held);
        if (n != 6) begin
          $display("stimulus line for phase %c is malformed", f_ph);
          abort_run();
        end
        ln_phase.push_back(f_ph);
        ln_cycles.push_back(f_cyc);
        ln_jv.push_back(f_jv);
        ln_data.push_back(f_jd);
        ln_rel.push_back(f_rel);
        ln_wr.push_back(f_wr);
        ln_held.push_back(f_held);
        total_cycles = total_cycles + f_cyc;
      end
    end
    $fclose(fd);
    limit_cycles = 4 * total_cycles + 100;

    repeat (5) @(posedge clk_in);
    rst_in <= 1'b0;

    for (int i = 0; i < ln_phase.size(); i++) begin
      for (int k = 0; k < ln_cycles[i]; k++) begin
        @(posedge clk_in);
        model_edge();
        phase = ln_phase[i];
        if (phase == "R") begin
          // fill and drain stretches of 32 cycles
          rnd = $random(seed);
          job_valid <= rnd[0];
          job_data <= rnd[31:16];
          rel_deadline <= rnd[11:4];
          worker_ready <= ((k % 64) < 32) ? (rnd[2] & rnd[3]) : (rnd[2] | rnd[3]);
        end else begin
          job_valid <= (k == 0) && (ln_jv[i] != 0);
          job_data <= job_data_t'(ln_data[i]);
          rel_deadline <= rel_deadline_t'(ln_rel[i]);
          worker_ready <= (ln_wr[i] != 0);
        end
        @(negedge clk_in);
        check_outputs();
        if (k == ln_cycles[i] - 1 && ln_held[i] != 255 && exp_tag.size() != ln_held[i]) begin
          report_error($sformatf("%0d jobs still held, expected %0d", exp_tag.size(),
                                 ln_held[i]));
        end
      end
    end

    if (exp_tag.size() != 0) begin
      report_error($sformatf("%0d accepted jobs never dispatched", exp_tag.size()));
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// ==== test/edf_stimulus.txt ====
# phase cycles job_valid job_data rel_deadline worker_ready held_at_end, all hex, ff = no check
# phases L latency, O order, F full, R random, D drain after random, T late
L 8 1 a001 05 1 0
O 2 1 b001 30 0 1
O 2 1 b002 0a 0 2
O 2 1 b003 50 0 3
O 2 1 b004 14 0 4
O 2 1 b005 3c 0 5
O 2 1 b006 28 0 6
O 12 0 0000 00 1 0
F 1 1 c001 50 0 ff
F 1 1 c002 4e 0 ff
F 1 1 c003 4c 0 ff
F 1 1 c004 4a 0 ff
F 1 1 c005 48 0 ff
F 1 1 c006 46 0 ff
F 1 1 c007 44 0 ff
F 1 1 c008 42 0 ff
F 1 1 c009 40 0 ff
F 1 1 c00a 3e 0 8
F 14 0 0000 00 1 0
R c8 0 0000 00 0 ff
D 1e 0 0000 00 1 0
T 2 1 d001 01 0 1
T 2 1 d002 01 0 2
T 2 1 d003 28 0 3
T c 0 0000 00 1 0

// ==== filelist.f ====
design/sched_pkg.sv
design/queue_pkg.sv
design/job_stamper.sv
design/free_slot_list.sv
design/tag_priority_queue.sv
design/job_dispatcher.sv
design/edf_scheduler_top.sv
test/edf_scheduler_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the EDF scheduler testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -f filelist.f --top-module edf_scheduler_tb \
  --Mdir obj_dir -o edf_scheduler_sim \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/edf_scheduler_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "ALL CHECKS PASSED" "$LOG" && echo "simulation passed" && exit 0 \
  || { echo "simulation failed, see $LOG"; exit 1; }
